/* hw/csr_pkg.sv */
/*
  Machine-mode CSR definitions for an RV32 core without S or U mode.
  mpp is fixed to machine mode and is not stored in mstatus_t.
  Counter group prefixes are the upper 7 bits of the CSR address.
*/
`default_nettype none

package csr_pkg;

  // implemented CSR numbers
  typedef enum logic [11:0] {
    CSR_MSTATUS       = 12'h300,
    CSR_MISA          = 12'h301,
    CSR_MTVEC         = 12'h305,
    CSR_MCOUNTINHIBIT = 12'h320,
    CSR_MSCRATCH      = 12'h340,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MTVAL         = 12'h343,
    CSR_MCYCLE        = 12'hB00,
    CSR_MINSTRET      = 12'hB02,
    CSR_MCYCLEH       = 12'hB80,
    CSR_MINSTRETH     = 12'hB82,
    CSR_MHARTID       = 12'hF14
  } csr_num_e;

  // counter group bases, as address prefixes
  // event setup 0x320, counter low 0xB00, counter high 0xB80
  localparam logic [6:0] CsrGrpEvent    = 7'h19;
  localparam logic [6:0] CsrGrpCounter  = 7'h58;
  localparam logic [6:0] CsrGrpCounterH = 7'h5C;

  // one address word, seen as a CSR number or as group plus counter index
  typedef union packed {
    csr_num_e num;
    struct packed {
      logic [6:0] grp;
      logic [4:0] idx;
    } hpm;
  } csr_addr_u;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  typedef struct packed {
    logic mie;
    logic mpie;
  } mstatus_t;

  localparam int unsigned MstatusMieBit  = 3;
  localparam int unsigned MstatusMpieBit = 7;

  // address bits 11:10 for read-only CSRs
  localparam logic [1:0] CsrReadOnlyBits = 2'b11;

  // C, I, X and MXL=1, without M
  localparam logic [31:0] MisaValue = 32'h4080_0104;

  function automatic logic [31:0] misa_with_m(input bit rv32m);
    return MisaValue | (32'(rv32m) << 12);
  endfunction

endpackage

`default_nettype wire

/* hw/hpm_pkg.sv */
/*
  Hardware performance monitor constants.
  Events are hardwired to counter indices 3 and up, in struct field order
  from the least significant bit.
*/
`default_nettype none

package hpm_pkg;

  // architectural counter indices
  localparam int unsigned HpmSlots      = 32;
  localparam int unsigned HpmIdxCycle   = 0;
  localparam int unsigned HpmIdxInstret = 2;
  localparam int unsigned HpmFirstEvent = 3;

  // hardwired events, one per configurable counter
  localparam int unsigned HpmMaxEvents  = 8;

  typedef struct packed {
    logic compressed;
    logic branch_taken;
    logic branch;
    logic jump;
    logic store;
    logic load;
    logic imiss;
    logic lsu_busy;
  } hpm_event_t;

endpackage

`default_nettype wire

/* hw/hpm_ctrl_if.sv */
/*
  Counter write path from the CSR logic to the counter bank.
  Strobes are one-hot over the counter index and last one cycle.
*/
`timescale 1ns/1ps
`default_nettype none

interface hpm_ctrl_if;

  logic [31:0] we_lo;
  logic [31:0] we_hi;
  logic        inhibit_we;
  logic [31:0] wdata;

  modport csr (
    output we_lo, we_hi, inhibit_we, wdata
  );

  modport bank (
    input we_lo, we_hi, inhibit_we, wdata
  );

endinterface

`default_nettype wire

/* hw/csr_machine_regs.sv */
/*
  Machine-mode CSRs with address decode and set/clear operations.
  Writes commit when instr_new_id_i is high; trap save wins over them.
  Counter values come in from the bank, this block only decodes them.
  mhpmevent registers are hardwired and ignore writes.
*/
`timescale 1ns/1ps
`default_nettype none

module csr_machine_regs
  import csr_pkg::*;
  import hpm_pkg::*;
#(
  parameter int unsigned HpmCounterNum = 8,
  parameter bit          Rv32m         = 1'b0
) (
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire logic        csr_access_i,
  input  wire logic        instr_new_id_i,
  input  wire csr_addr_u   csr_addr_i,
  input  wire csr_op_e     csr_op_i,
  input  wire logic [31:0] csr_wdata_i,
  input  wire logic [31:0] hpm_rdata_i,
  input  wire logic [31:0] hpm_inhibit_i,
  input  wire logic [9:0]  hartid_i,
  input  wire logic        csr_save_cause_i,
  input  wire logic        csr_restore_mret_i,
  input  wire logic [31:0] pc_i,
  input  wire logic [5:0]  csr_mcause_i,
  input  wire logic [31:0] csr_mtval_i,
  output logic [31:0]      csr_rdata_o,
  output logic             illegal_csr_insn_o,
  output logic             m_irq_enable_o,
  output logic [31:0]      csr_mepc_o,
  output logic [31:0]      csr_mtvec_o,
  output logic [4:0]       hpm_idx_o,
  output logic             hpm_hi_o,
  hpm_ctrl_if.csr          hpm_ctrl_o
);

  mstatus_t    mstatus_q, mstatus_d;
  logic [31:0] mscratch_q, mscratch_d;
  logic [31:0] mtvec_q, mtvec_d;
  logic [31:0] mepc_q, mepc_d;
  logic [5:0]  mcause_q, mcause_d;
  logic [31:0] mtval_q, mtval_d;

  logic [6:0]  csr_grp;
  logic [4:0]  csr_idx;
  logic        evt_present;
  logic        cnt_present;
  logic        unknown_csr;
  logic        illegal_write;
  logic        csr_wreq;
  logic        csr_we;
  logic [31:0] rdata;
  logic [31:0] wdata_int;

  ////////////////////////////////////////////////////////////
  // decode and read
  ////////////////////////////////////////////////////////////

  assign csr_grp = csr_addr_i.hpm.grp;
  assign csr_idx = csr_addr_i.hpm.idx;

  // index 1 is the reserved mtime slot
  assign evt_present = (int'(csr_idx) >= HpmFirstEvent) &&
                       (int'(csr_idx) < HpmFirstEvent + HpmCounterNum);
  assign cnt_present = evt_present || (int'(csr_idx) == HpmIdxCycle) ||
                       (int'(csr_idx) == HpmIdxInstret);

  assign hpm_idx_o = csr_idx;
  assign hpm_hi_o  = (csr_grp == CsrGrpCounterH);

  always_comb begin
    rdata       = '0;
    unknown_csr = 1'b0;
    unique case (csr_addr_i.num)
      CSR_MHARTID:  rdata = {22'b0, hartid_i};
      CSR_MISA:     rdata = misa_with_m(Rv32m);
      // mpp always reads as machine mode
      CSR_MSTATUS:  rdata = {19'b0, 2'b11, 3'b0, mstatus_q.mpie, 3'b0, mstatus_q.mie, 3'b0};
      CSR_MSCRATCH: rdata = mscratch_q;
      CSR_MTVEC:    rdata = mtvec_q;
      CSR_MEPC:     rdata = mepc_q;
      CSR_MCAUSE:   rdata = {mcause_q[5], 26'b0, mcause_q[4:0]};
      CSR_MTVAL:    rdata = mtval_q;
      CSR_MCOUNTINHIBIT: rdata = hpm_inhibit_i;
      CSR_MCYCLE, CSR_MCYCLEH, CSR_MINSTRET, CSR_MINSTRETH: rdata = hpm_rdata_i;
      default: begin
        if (csr_grp == CsrGrpCounter || csr_grp == CsrGrpCounterH) begin
          rdata       = hpm_rdata_i;
          unknown_csr = !cnt_present;
        end else if (csr_grp == CsrGrpEvent) begin
          // hardwired selector, one event per counter
          rdata       = evt_present ? (32'd1 << csr_idx) : 32'd0;
          unknown_csr = !evt_present;
        end else begin
          unknown_csr = 1'b1;
        end
      end
    endcase
  end

  assign csr_rdata_o = rdata;

  ////////////////////////////////////////////////////////////
  // operation and write enable
  ////////////////////////////////////////////////////////////

  always_comb begin
    csr_wreq = 1'b1;
    unique case (csr_op_i)
      CSR_OP_WRITE: wdata_int = csr_wdata_i;
      CSR_OP_SET:   wdata_int = csr_wdata_i | rdata;
      CSR_OP_CLEAR: wdata_int = ~csr_wdata_i & rdata;
      default: begin
        wdata_int = csr_wdata_i;
        csr_wreq  = 1'b0;
      end
    endcase
  end

  // misa is read-only too, although it lies outside the read-only field
  assign illegal_write      = csr_wreq && ((csr_addr_i.num[11:10] == CsrReadOnlyBits) ||
                                           (csr_addr_i.num == CSR_MISA));
  assign illegal_csr_insn_o = csr_access_i && (unknown_csr || illegal_write);

  assign csr_we = csr_access_i && instr_new_id_i && csr_wreq &&
                  !illegal_csr_insn_o && !csr_save_cause_i;

  // counter and inhibit strobes
  always_comb begin
    hpm_ctrl_o.we_lo      = '0;
    hpm_ctrl_o.we_hi      = '0;
    hpm_ctrl_o.inhibit_we = 1'b0;
    if (csr_we) begin
      if (csr_addr_i.num == CSR_MCOUNTINHIBIT) begin
        hpm_ctrl_o.inhibit_we = 1'b1;
      end else if (csr_grp == CsrGrpCounter) begin
        hpm_ctrl_o.we_lo[csr_idx] = 1'b1;
      end else if (csr_grp == CsrGrpCounterH) begin
        hpm_ctrl_o.we_hi[csr_idx] = 1'b1;
      end
    end
  end

  assign hpm_ctrl_o.wdata = wdata_int;

  ////////////////////////////////////////////////////////////
  // machine registers
  ////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_d  = mstatus_q;
    mscratch_d = mscratch_q;
    mtvec_d    = mtvec_q;
    mepc_d     = mepc_q;
    mcause_d   = mcause_q;
    mtval_d    = mtval_q;

    if (csr_we) begin
      unique case (csr_addr_i.num)
        CSR_MSTATUS: begin
          mstatus_d.mie  = wdata_int[MstatusMieBit];
          mstatus_d.mpie = wdata_int[MstatusMpieBit];
        end
        CSR_MSCRATCH: mscratch_d = wdata_int;
        CSR_MTVEC:    mtvec_d    = {wdata_int[31:1], 1'b0};
        CSR_MEPC:     mepc_d     = {wdata_int[31:1], 1'b0};
        CSR_MCAUSE:   mcause_d   = {wdata_int[31], wdata_int[4:0]};
        CSR_MTVAL:    mtval_d    = wdata_int;
        default: ;
      endcase
    end

    // trap entry and return
    if (csr_save_cause_i) begin
      mstatus_d.mpie = mstatus_q.mie;
      mstatus_d.mie  = 1'b0;
      mepc_d         = {pc_i[31:1], 1'b0};
      mcause_d       = csr_mcause_i;
      mtval_d        = csr_mtval_i;
    end else if (csr_restore_mret_i) begin
      mstatus_d.mie  = mstatus_q.mpie;
      mstatus_d.mpie = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_q  <= '0;
      mscratch_q <= '0;
      mtvec_q    <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
    end else begin
      mstatus_q  <= mstatus_d;
      mscratch_q <= mscratch_d;
      mtvec_q    <= mtvec_d;
      mepc_q     <= mepc_d;
      mcause_q   <= mcause_d;
      mtval_q    <= mtval_d;
    end
  end

  assign m_irq_enable_o = mstatus_q.mie;
  assign csr_mepc_o     = mepc_q;
  assign csr_mtvec_o    = mtvec_q;

endmodule

`default_nettype wire

/* hw/hpm_event_select.sv */
/*
  mcountinhibit and per-counter increment enables.
  Bit 1 of mcountinhibit is always zero; absent counters read as inhibited.
*/
`timescale 1ns/1ps
`default_nettype none

module hpm_event_select
  import hpm_pkg::*;
#(
  parameter int unsigned HpmCounterNum = 8
) (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       instr_ret_i,
  input  wire hpm_event_t events_i,
  input  wire logic       pc_set_i,
  hpm_ctrl_if.bank        hpm_ctrl_i,
  output logic [31:0]     incr_o,
  output logic [31:0]     inhibit_o
);

  logic [31:0]             inhibit_q;
  logic [HpmSlots-1:0]     absent;
  logic [HpmSlots-1:0]     incr_raw;
  logic [HpmMaxEvents-1:0] event_vec;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inhibit_q <= '0;
    end else if (hpm_ctrl_i.inhibit_we) begin
      inhibit_q <= {hpm_ctrl_i.wdata[31:2], 1'b0, hpm_ctrl_i.wdata[0]};
    end
  end

  // imiss excludes the cycles where the pc is redirected
  assign event_vec = {events_i.compressed, events_i.branch_taken, events_i.branch,
                      events_i.jump, events_i.store, events_i.load,
                      events_i.imiss & ~pc_set_i, events_i.lsu_busy};

  always_comb begin
    incr_raw                = '0;
    incr_raw[HpmIdxCycle]   = 1'b1;
    incr_raw[HpmIdxInstret] = instr_ret_i;
    for (int i = 0; i < HpmMaxEvents; i++) begin
      if (i < HpmCounterNum) begin
        incr_raw[HpmFirstEvent + i] = event_vec[i];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < HpmSlots; i++) begin
      absent[i] = (i >= HpmFirstEvent + HpmCounterNum);
    end
  end

  assign inhibit_o = inhibit_q | absent;
  assign incr_o    = incr_raw & ~inhibit_o;

endmodule

`default_nettype wire

/* hw/hpm_counter.sv */
/*
  One performance counter, 64 bits wide and masked to Width bits.
  Width must be 33 to 64. A half write wins over the increment
  of the same cycle; bits above Width are dropped.
*/
`timescale 1ns/1ps
`default_nettype none

module hpm_counter #(
  parameter int unsigned Width = 64,
  parameter int unsigned Idx   = 0
) (
  input  wire logic   clk_i,
  input  wire logic   rst_ni,
  input  wire logic   incr_i,
  hpm_ctrl_if.bank    hpm_ctrl_i,
  output logic [63:0] count_o
);

  localparam logic [63:0] Mask = {64{1'b1}} >> (64 - Width);

  logic [63:0] count_q;
  logic [63:0] count_d;

  always_comb begin
    if (hpm_ctrl_i.we_lo[Idx]) begin
      count_d = {count_q[63:32], hpm_ctrl_i.wdata};
    end else if (hpm_ctrl_i.we_hi[Idx]) begin
      count_d = {hpm_ctrl_i.wdata, count_q[31:0]};
    end else if (incr_i) begin
      count_d = count_q + 64'd1;
    end else begin
      count_d = count_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      count_q <= count_d & Mask;
    end
  end

  assign count_o = count_q;

endmodule

`default_nettype wire

/* hw/hpm_read_mux.sv */
/*
  Read select over the counter bank.
  Reserved index 1 and indices past the configured counters read as zero.
*/
`timescale 1ns/1ps
`default_nettype none

module hpm_read_mux
  import hpm_pkg::*;
#(
  parameter int unsigned HpmCounterNum = 8
) (
  input  wire logic [63:0] counts_i [HpmSlots],
  input  wire logic [4:0]  idx_i,
  input  wire logic        hi_i,
  output logic [31:0]      rdata_o
);

  logic        present;
  logic [63:0] sel;

  assign present = (int'(idx_i) == HpmIdxCycle) || (int'(idx_i) == HpmIdxInstret) ||
                   ((int'(idx_i) >= HpmFirstEvent) &&
                    (int'(idx_i) < HpmFirstEvent + HpmCounterNum));

  always_comb begin
    if (present) begin
      sel = counts_i[idx_i];
    end else begin
      sel = '0;
    end
  end

  // upper or lower word
  assign rdata_o = hi_i ? sel[63:32] : sel[31:0];

endmodule

`default_nettype wire

/* hw/csr_file_top.sv */
/*
  Machine CSR file with performance counters, plain ports only.
  HpmCounterNum is 0 to 8, HpmCounterWidth is 33 to 64.
  mcycle and minstret are always 64 bits wide.
*/
`timescale 1ns/1ps
`default_nettype none

module csr_file_top
  import csr_pkg::*;
  import hpm_pkg::*;
#(
  parameter int unsigned HpmCounterNum   = 8,
  parameter int unsigned HpmCounterWidth = 40,
  parameter bit          Rv32m           = 1'b0
) (
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  // CSR access
  input  wire logic        csr_access_i,
  input  wire logic [11:0] csr_addr_i,
  input  wire logic [1:0]  csr_op_i,
  input  wire logic [31:0] csr_wdata_i,
  input  wire logic        instr_new_id_i,
  input  wire logic [9:0]  hartid_i,
  // trap control
  input  wire logic        csr_save_cause_i,
  input  wire logic        csr_restore_mret_i,
  input  wire logic [31:0] pc_i,
  input  wire logic [5:0]  csr_mcause_i,
  input  wire logic [31:0] csr_mtval_i,
  // core events
  input  wire logic        instr_ret_i,
  input  wire logic        pc_set_i,
  input  wire logic        lsu_busy_i,
  input  wire logic        imiss_i,
  input  wire logic        mem_load_i,
  input  wire logic        mem_store_i,
  input  wire logic        jump_i,
  input  wire logic        branch_i,
  input  wire logic        branch_taken_i,
  input  wire logic        instr_ret_compressed_i,
  output logic [31:0]      csr_rdata_o,
  output logic             illegal_csr_insn_o,
  output logic             m_irq_enable_o,
  output logic [31:0]      csr_mepc_o,
  output logic [31:0]      csr_mtvec_o
);

  hpm_ctrl_if hpm_ctrl ();

  hpm_event_t  events;
  logic [31:0] hpm_rdata;
  logic [31:0] hpm_inhibit;
  logic [31:0] hpm_incr;
  logic [4:0]  hpm_idx;
  logic        hpm_hi;
  logic [63:0] counts [HpmSlots];

  assign events.lsu_busy     = lsu_busy_i;
  assign events.imiss        = imiss_i;
  assign events.load         = mem_load_i;
  assign events.store        = mem_store_i;
  assign events.jump         = jump_i;
  assign events.branch       = branch_i;
  assign events.branch_taken = branch_taken_i;
  assign events.compressed   = instr_ret_compressed_i;

  csr_machine_regs #(
    .HpmCounterNum (HpmCounterNum),
    .Rv32m         (Rv32m)
  ) u_machine_regs (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .csr_access_i       (csr_access_i),
    .instr_new_id_i     (instr_new_id_i),
    .csr_addr_i         (csr_addr_u'(csr_addr_i)),
    .csr_op_i           (csr_op_e'(csr_op_i)),
    .csr_wdata_i        (csr_wdata_i),
    .hpm_rdata_i        (hpm_rdata),
    .hpm_inhibit_i      (hpm_inhibit),
    .hartid_i           (hartid_i),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .pc_i               (pc_i),
    .csr_mcause_i       (csr_mcause_i),
    .csr_mtval_i        (csr_mtval_i),
    .csr_rdata_o        (csr_rdata_o),
    .illegal_csr_insn_o (illegal_csr_insn_o),
    .m_irq_enable_o     (m_irq_enable_o),
    .csr_mepc_o         (csr_mepc_o),
    .csr_mtvec_o        (csr_mtvec_o),
    .hpm_idx_o          (hpm_idx),
    .hpm_hi_o           (hpm_hi),
    .hpm_ctrl_o         (hpm_ctrl)
  );

  hpm_event_select #(
    .HpmCounterNum (HpmCounterNum)
  ) u_event_select (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .instr_ret_i (instr_ret_i),
    .events_i    (events),
    .pc_set_i    (pc_set_i),
    .hpm_ctrl_i  (hpm_ctrl),
    .incr_o      (hpm_incr),
    .inhibit_o   (hpm_inhibit)
  );

  ////////////////////////////////////////////////////////////
  // counter bank
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < HpmSlots; i++) begin : g_slot
    if (i == HpmIdxCycle || i == HpmIdxInstret ||
        (i >= HpmFirstEvent && i < HpmFirstEvent + HpmCounterNum)) begin : g_counter
      hpm_counter #(
        .Width ((i < HpmFirstEvent) ? 64 : HpmCounterWidth),
        .Idx   (i)
      ) u_counter (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .incr_i     (hpm_incr[i]),
        .hpm_ctrl_i (hpm_ctrl),
        .count_o    (counts[i])
      );
    end else begin : g_absent
      assign counts[i] = '0;
    end
  end

  hpm_read_mux #(
    .HpmCounterNum (HpmCounterNum)
  ) u_read_mux (
    .counts_i (counts),
    .idx_i    (hpm_idx),
    .hi_i     (hpm_hi),
    .rdata_o  (hpm_rdata)
  );

endmodule

`default_nettype wire

/* test/csr_file_tb_table.svh */
/*
  Stimulus table for the CSR file testbench, one row per step.
  Included inside csr_file_tb and uses its constants, so the expected
  values follow the counter count, counter width and RV32M set there.
*/
`ifndef CSR_FILE_TB_TABLE_SVH
`define CSR_FILE_TB_TABLE_SVH

// row kinds: plain access, access with LCG data, trap entry, mret, load pulses
typedef enum logic [2:0] {ACT_CSR, ACT_RAND, ACT_TRAP, ACT_MRET, ACT_LOAD} act_e;
typedef enum logic [2:0] {CHK_NONE, CHK_VALUE, CHK_MODEL, CHK_ILLEGAL, CHK_IRQ} chk_e;

typedef struct packed {
  act_e        act;
  csr_op_e     op;
  logic [11:0] addr;
  logic [31:0] wdata;
  chk_e        chk;
  logic [31:0] exp_val;
} entry_t;

entry_t table_q[$];

function automatic entry_t row(input act_e act, input csr_op_e op, input logic [11:0] addr,
                               input logic [31:0] wdata, input chk_e chk,
                               input logic [31:0] exp_val);
  return '{act, op, addr, wdata, chk, exp_val};
endfunction

// columns: kind, operation, address, write data, check, expected value
// trap rows carry the pc in the data column, load rows the pulse count
task automatic build_table();
  // scratch registers against the set/clear model
  table_q.push_back(row(ACT_RAND, CSR_OP_WRITE, CSR_MSCRATCH, '0, CHK_NONE, '0));
  table_q.push_back(row(ACT_RAND, CSR_OP_SET,   CSR_MSCRATCH, '0, CHK_NONE, '0));
  table_q.push_back(row(ACT_CSR,  CSR_OP_READ,  CSR_MSCRATCH, '0, CHK_MODEL, '0));
  table_q.push_back(row(ACT_RAND, CSR_OP_CLEAR, CSR_MSCRATCH, '0, CHK_NONE, '0));
  table_q.push_back(row(ACT_CSR,  CSR_OP_READ,  CSR_MSCRATCH, '0, CHK_MODEL, '0));
  table_q.push_back(row(ACT_RAND, CSR_OP_WRITE, CSR_MTVAL, '0, CHK_NONE, '0));
  table_q.push_back(row(ACT_RAND, CSR_OP_CLEAR, CSR_MTVAL, '0, CHK_NONE, '0));
  table_q.push_back(row(ACT_RAND, CSR_OP_SET,   CSR_MTVAL, '0, CHK_NONE, '0));
  table_q.push_back(row(ACT_CSR,  CSR_OP_READ,  CSR_MTVAL, '0, CHK_MODEL, '0));
  // bit 0 of mepc and mtvec is dropped
  table_q.push_back(row(ACT_CSR, CSR_OP_WRITE, CSR_MEPC, 32'h8000_1235, CHK_NONE, '0));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ,  CSR_MEPC, '0, CHK_VALUE, 32'h8000_1234));
  table_q.push_back(row(ACT_CSR, CSR_OP_WRITE, CSR_MTVEC, 32'h0000_0101, CHK_NONE, '0));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ,  CSR_MTVEC, '0, CHK_VALUE, 32'h0000_0100));

  // illegal accesses
  table_q.push_back(row(ACT_CSR, CSR_OP_READ, 12'h7C0, '0, CHK_ILLEGAL, 32'd1));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ, 12'hB01, '0, CHK_ILLEGAL, 32'd1));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ, LastCounter + 12'd1, '0, CHK_ILLEGAL, 32'd1));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ, LastCounter, '0, CHK_ILLEGAL, 32'd0));
  table_q.push_back(row(ACT_CSR, CSR_OP_WRITE, CSR_MHARTID, 32'd1, CHK_ILLEGAL, 32'd1));
  // misa is read-only as well
  table_q.push_back(row(ACT_CSR, CSR_OP_WRITE, CSR_MISA, 32'd0, CHK_ILLEGAL, 32'd1));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ, CSR_MISA, '0, CHK_VALUE, MisaExpected));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ, CSR_MHARTID, '0, CHK_VALUE, 32'(HartId)));

  // trap entry and mret, mpp always reads as machine mode
  table_q.push_back(row(ACT_CSR, CSR_OP_SET, CSR_MSTATUS, 32'h8, CHK_NONE, '0));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ, CSR_MSTATUS, '0, CHK_VALUE, 32'h0000_1808));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ, CSR_MSTATUS, '0, CHK_IRQ, 32'd1));
  table_q.push_back(row(ACT_TRAP, CSR_OP_READ, '0, TrapPc, CHK_NONE, 32'd0));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ, CSR_MEPC, '0, CHK_VALUE, TrapPc & ~32'd1));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ, CSR_MCAUSE, '0, CHK_VALUE, 32'h8000_000B));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ, CSR_MTVAL, '0, CHK_VALUE, TrapTval));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ, CSR_MSTATUS, '0, CHK_VALUE, 32'h0000_1880));
  table_q.push_back(row(ACT_MRET, CSR_OP_READ, '0, '0, CHK_NONE, 32'd1));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ, CSR_MSTATUS, '0, CHK_VALUE, 32'h0000_1888));

  // mcycle frozen, bit 1 of the write is dropped
  table_q.push_back(row(ACT_CSR, CSR_OP_WRITE, CSR_MCOUNTINHIBIT, 32'h3, CHK_NONE, '0));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ, CSR_MCOUNTINHIBIT, '0, CHK_VALUE,
                        AbsentMask | 32'h1));
  table_q.push_back(row(ACT_CSR, CSR_OP_WRITE, CSR_MCYCLE, 32'h1234_5678, CHK_NONE, '0));
  table_q.push_back(row(ACT_CSR, CSR_OP_WRITE, CSR_MCYCLEH, 32'h9ABC_DEF0, CHK_NONE, '0));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ, CSR_MCYCLE, '0, CHK_VALUE, 32'h1234_5678));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ, CSR_MCYCLEH, '0, CHK_VALUE, 32'h9ABC_DEF0));

  // only counter 5 (load) runs; start just below the carry into the high half
  table_q.push_back(row(ACT_CSR, CSR_OP_WRITE, CSR_MCOUNTINHIBIT, ~32'h20, CHK_NONE, '0));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ, CSR_MCOUNTINHIBIT, '0, CHK_VALUE, ~32'h22));
  table_q.push_back(row(ACT_CSR, CSR_OP_WRITE, 12'hB05, 32'hFFFF_FFFD, CHK_NONE, '0));
  table_q.push_back(row(ACT_CSR, CSR_OP_WRITE, 12'hB85, 32'h0000_0012, CHK_NONE, '0));
  table_q.push_back(row(ACT_LOAD, CSR_OP_READ, '0, 32'd5, CHK_NONE, '0));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ, 12'hB05, '0, CHK_VALUE, 32'h0000_0002));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ, 12'hB85, '0, CHK_VALUE, 32'h0000_0013));
  table_q.push_back(row(ACT_CSR, CSR_OP_WRITE, 12'hB85, 32'hFFFF_FFFF, CHK_NONE, '0));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ, 12'hB85, '0, CHK_VALUE, HiMask));
  table_q.push_back(row(ACT_CSR, CSR_OP_READ, CSR_MCYCLE, '0, CHK_VALUE, 32'h1234_5678));
endtask

`endif

/* test/csr_file_tb.sv */
/*
  Table driven testbench for the machine CSR file.
  Inputs change on the rising edge, outputs are checked on the falling edge.
  Runs the default configuration: 8 event counters of 40 bits, no RV32M.
*/
`timescale 1ns/1ps
`default_nettype none

module csr_file_tb
  import csr_pkg::*;
  import hpm_pkg::*;
();

  localparam int unsigned HpmCounterNum   = 8;
  localparam int unsigned HpmCounterWidth = 40;
  localparam bit          Rv32m           = 1'b0;
  localparam int          ClkPeriod       = 20;
  localparam int          WaitLimit       = 16;

  localparam logic [9:0]  HartId   = 10'h2C5;
  localparam logic [31:0] TrapPc   = 32'h0000_4A67;
  localparam logic [5:0]  TrapCause = 6'h2B;
  localparam logic [31:0] TrapTval = 32'hDEAD_0BAD;

  // MXL=1, X, I and C, plus M when RV32M is on
  localparam logic [31:0] MisaExpected = (32'd1 << 30) | (32'd1 << 23) | (32'd1 << 8) |
                                         (32'd1 << 2) | (32'(Rv32m) << 12);
  localparam logic [31:0] AbsentMask  = 32'hFFFF_FFFF << (HpmFirstEvent + HpmCounterNum);
  localparam logic [31:0] HiMask      = (32'd1 << (HpmCounterWidth - 32)) - 32'd1;
  localparam logic [11:0] LastCounter = 12'hB00 + 12'(HpmFirstEvent + HpmCounterNum - 1);

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        csr_access_i;
  logic [11:0] csr_addr_i;
  logic [1:0]  csr_op_i;
  logic [31:0] csr_wdata_i;
  logic        instr_new_id_i;
  logic [9:0]  hartid_i;
  logic        csr_save_cause_i;
  logic        csr_restore_mret_i;
  logic [31:0] pc_i;
  logic [5:0]  csr_mcause_i;
  logic [31:0] csr_mtval_i;
  logic        instr_ret_i;
  logic        pc_set_i;
  logic        lsu_busy_i;
  logic        imiss_i;
  logic        mem_load_i;
  logic        mem_store_i;
  logic        jump_i;
  logic        branch_i;
  logic        branch_taken_i;
  logic        instr_ret_compressed_i;
  logic [31:0] csr_rdata_o;
  logic        illegal_csr_insn_o;
  logic        m_irq_enable_o;
  logic [31:0] csr_mepc_o;
  logic [31:0] csr_mtvec_o;

  int          checks   = 0;
  int          errors   = 0;
  int          timeouts = 0;
  logic [31:0] lcg_state = 32'ha72ca9c4;
  logic [31:0] model_scratch = '0;
  logic [31:0] model_tval = '0;

  `include "csr_file_tb_table.svh"

  csr_file_top #(
    .HpmCounterNum   (HpmCounterNum),
    .HpmCounterWidth (HpmCounterWidth),
    .Rv32m           (Rv32m)
  ) u_csr_file_top (.*);

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] model_value(input logic [11:0] addr);
    return (addr == CSR_MTVAL) ? model_tval : model_scratch;
  endfunction

  // software view of write, set and clear
  task automatic update_model(input logic [11:0] addr, input csr_op_e op,
                              input logic [31:0] data);
    logic [31:0] cur;
    cur = model_value(addr);
    case (op)
      CSR_OP_WRITE: cur = data;
      CSR_OP_SET:   cur = cur | data;
      CSR_OP_CLEAR: cur = cur & ~data;
      default: ;
    endcase
    if (addr == CSR_MTVAL) begin
      model_tval = cur;
    end else begin
      model_scratch = cur;
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp_val);
    checks++;
    assert (got === exp_val) else begin
      errors++;
      $display("** Error @ %0t ns: %s got %h, expected %h", $time, what, got, exp_val);
    end
  endtask

  task automatic drive_idle();
    csr_access_i       <= 1'b0;
    instr_new_id_i     <= 1'b0;
    csr_op_i           <= CSR_OP_READ;
    csr_save_cause_i   <= 1'b0;
    csr_restore_mret_i <= 1'b0;
  endtask

  task automatic wait_irq_level(input logic level);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (m_irq_enable_o !== level && cycles < WaitLimit) begin
      @(negedge clk_i);
      cycles++;
    end
    if (m_irq_enable_o !== level) begin
      timeouts++;
      $display("timeout: m_irq_enable_o did not go to %0b within %0d cycles", level,
               WaitLimit);
    end
  endtask

  task automatic apply_row(input entry_t e);
    logic [31:0] data;
    data = e.wdata;
    case (e.act)
      ACT_CSR, ACT_RAND: begin
        if (e.act == ACT_RAND) begin
          data = next_random();
        end
        @(posedge clk_i);
        drive_idle();
        csr_access_i   <= 1'b1;
        csr_addr_i     <= e.addr;
        csr_op_i       <= e.op;
        csr_wdata_i    <= data;
        instr_new_id_i <= (e.op != CSR_OP_READ);
        @(negedge clk_i);
        case (e.chk)
          CHK_VALUE: begin
            check_value($sformatf("read of %h", e.addr), csr_rdata_o, e.exp_val);
            // the trap vector port follows the register
            if (e.addr == CSR_MTVEC) begin
              check_value("csr_mtvec_o", csr_mtvec_o, e.exp_val);
            end
          end
          CHK_MODEL:   check_value($sformatf("model read of %h", e.addr), csr_rdata_o,
                                   model_value(e.addr));
          CHK_ILLEGAL: check_value($sformatf("illegal flag at %h", e.addr),
                                   32'(illegal_csr_insn_o), e.exp_val);
          CHK_IRQ:     check_value("m_irq_enable_o", 32'(m_irq_enable_o), e.exp_val);
          default: ;
        endcase
        if (e.act == ACT_RAND) begin
          update_model(e.addr, e.op, data);
        end
      end
      ACT_TRAP: begin
        @(posedge clk_i);
        drive_idle();
        csr_save_cause_i <= 1'b1;
        pc_i             <= e.wdata;
        csr_mcause_i     <= TrapCause;
        csr_mtval_i      <= TrapTval;
        @(posedge clk_i);
        csr_save_cause_i <= 1'b0;
        wait_irq_level(e.exp_val[0]);
        check_value("csr_mepc_o after trap", csr_mepc_o, e.wdata & ~32'd1);
      end
      ACT_MRET: begin
        @(posedge clk_i);
        drive_idle();
        csr_restore_mret_i <= 1'b1;
        @(posedge clk_i);
        csr_restore_mret_i <= 1'b0;
        wait_irq_level(e.exp_val[0]);
      end
      ACT_LOAD: begin
        // one increment per edge that sees the load event high
        @(posedge clk_i);
        drive_idle();
        mem_load_i <= 1'b1;
        for (int k = 0; k < int'(e.wdata); k++) begin
          @(posedge clk_i);
        end
        mem_load_i <= 1'b0;
      end
      default: ;
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_ni                 <= 1'b0;
    csr_addr_i             <= '0;
    csr_wdata_i            <= '0;
    hartid_i               <= HartId;
    pc_i                   <= '0;
    csr_mcause_i           <= '0;
    csr_mtval_i            <= '0;
    instr_ret_i            <= 1'b0;
    pc_set_i               <= 1'b0;
    lsu_busy_i             <= 1'b0;
    imiss_i                <= 1'b0;
    mem_load_i             <= 1'b0;
    mem_store_i            <= 1'b0;
    jump_i                 <= 1'b0;
    branch_i               <= 1'b0;
    branch_taken_i         <= 1'b0;
    instr_ret_compressed_i <= 1'b0;
    drive_idle();
    build_table();

    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int i = 0; i < table_q.size() && timeouts == 0; i++) begin
      apply_row(table_q[i]);
    end
    @(posedge clk_i);
    drive_idle();
    @(posedge clk_i);

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+test
hw/csr_pkg.sv
hw/hpm_pkg.sv
hw/hpm_ctrl_if.sv
hw/csr_machine_regs.sv
hw/hpm_event_select.sv
hw/hpm_counter.sv
hw/hpm_read_mux.sv
hw/csr_file_top.sv
test/csr_file_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CSR file testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
  --top-module csr_file_tb \
  -f project.f \
  --Mdir obj_dir \
  -o csr_file_sim

./obj_dir/csr_file_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx '>>> PASS' sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi
